/* filelist.f */
isa_pkg.sv
hazard_pkg.sv
instr_decoder.sv
pipe_tracker.sv
hazard_unit.sv
hazard_ctrl_top.sv
tb_hazard_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_hazard_ctrl
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_hazard_ctrl.sv */
module tb_hazard_ctrl;

    localparam int          clk_period      = 10;
    localparam int          reset_cycles    = 4;
    localparam int          directed_cycles = 40;                   // upper bound of the script
    localparam int          random_cycles   = 300;
    localparam int          timeout_limit   =
        (reset_cycles + directed_cycles + random_cycles + 100) * clk_period;
    localparam logic [31:0] pc_limit        = 32'h0000_3ffc;        // DUT default
    localparam logic [31:0] pc_run          = 32'h0000_0100;        // inside imem
    localparam logic [31:0] pc_out          = 32'h0000_4000;        // past the program

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic [31:0]                instr;
    logic [31:0]                pc;
    logic                       condition_satisfied;
    logic                       cpu_pause;
    logic                       uart_complete;
    hazard_pkg::stage_ctrl_t    hazard_control;
    hazard_pkg::cpu_state_e     cpu_state;
    hazard_pkg::issue_e         issue_type;

    int                         errors = 0;
    int                         cyc    = 0;                         // posedges seen
    hazard_pkg::decoded_instr_t d;                                  // reference decode of instr
    hazard_pkg::pipe_info_t     d_slot;
    hazard_pkg::pipe_info_t     m_ex;                               // model of the EX slot
    hazard_pkg::pipe_info_t     m_mem;                              // model of the MEM slot
    hazard_pkg::cpu_state_e     exp_state;
    hazard_pkg::issue_e         exp_issue;
    hazard_pkg::issue_e         exp_issue_d;                        // what issue_type should show
    hazard_pkg::stage_ctrl_t    exp_ctrl;

    hazard_ctrl_top u_dut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .instr               (instr),
        .pc                  (pc),
        .condition_satisfied (condition_satisfied),
        .cpu_pause           (cpu_pause),
        .uart_complete       (uart_complete),
        .hazard_control      (hazard_control),
        .cpu_state           (cpu_state),
        .issue_type          (issue_type)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic hazard_pkg::stage_ctrl_t fill_codes(input hazard_pkg::stage_ctrl_e code);
        hazard_pkg::stage_ctrl_t c;
        for (int i = 0; i < hazard_pkg::stage_cnt; i++) c[i] = code;
        return c;
    endfunction

    // instruction classes straight from the field layout
    function automatic hazard_pkg::decoded_instr_t decode_word(input logic [31:0] w);
        hazard_pkg::decoded_instr_t r;
        logic [5:0]                 op;
        op            = w[31:26];
        r             = '0;
        r.reg_1_idx   = w[25:21];
        r.reg_2_idx   = w[20:16];
        r.j           = op == isa_pkg::op_j;
        r.jal         = op == isa_pkg::op_jal;
        r.jr          = op == isa_pkg::op_rtype && w[5:0] == isa_pkg::fn_jr;
        r.r_type      = op == isa_pkg::op_rtype && !r.jr;
        r.branch      = op == isa_pkg::op_beq || op == isa_pkg::op_bne;
        r.load        = op == isa_pkg::op_lw;
        r.store       = op == isa_pkg::op_sw;
        r.i_type      = op == isa_pkg::op_addi || op == isa_pkg::op_andi ||
                        op == isa_pkg::op_ori || op == isa_pkg::op_lui;
        r.reg_1_valid = !(r.j || r.jal);                            // j/jal carry no rs
        r.reg_2_valid = r.r_type || r.branch || r.store;
        r.dest_idx    = r.r_type ? w[15:11] : r.jal ? 5'd31 : (r.i_type || r.load) ? w[20:16] : 5'd0;
        r.reg_write   = (r.r_type || r.i_type || r.load || r.jal) && r.dest_idx != 5'd0;
        return r;
    endfunction

    function automatic logic depends_on(input hazard_pkg::pipe_info_t     s,
                                        input hazard_pkg::decoded_instr_t i);
        return s.reg_write && ((i.reg_1_valid && i.reg_1_idx == s.dest_idx) ||
                               (i.reg_2_valid && i.reg_2_idx == s.dest_idx));
    endfunction

    function automatic hazard_pkg::pipe_info_t advance_slot(input hazard_pkg::stage_ctrl_e c,
                                                            input hazard_pkg::pipe_info_t  up,
                                                            input hazard_pkg::pipe_info_t  cur);
        if (c == hazard_pkg::ctrl_normal) return up;
        if (c == hazard_pkg::ctrl_clear) return '0;                 // bubble
        return cur;
    endfunction

    function automatic logic [31:0] encode_r(input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] rd, input logic [5:0] fn);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt);
        return {op, rs, rt, 16'h0004};
    endfunction

    // registers limited to 0..7 so conflicts come often
    function automatic logic [31:0] random_instr(input logic [31:0] r);
        logic [5:0] op;
        logic [5:0] fn;
        case (r[3:0])
            4'd0, 4'd1, 4'd2: op = isa_pkg::op_rtype;
            4'd3:             op = isa_pkg::op_j;
            4'd4:             op = isa_pkg::op_jal;
            4'd5:             op = isa_pkg::op_beq;
            4'd6:             op = isa_pkg::op_bne;
            4'd7, 4'd8:       op = isa_pkg::op_addi;
            4'd9:             op = isa_pkg::op_ori;
            4'd10:            op = isa_pkg::op_lui;
            4'd11, 4'd12:     op = isa_pkg::op_lw;
            4'd13:            op = isa_pkg::op_sw;
            default:          op = r[31:26];                        // unknown opcodes as well
        endcase
        case (r[6:4])
            3'd0:    fn = isa_pkg::fn_jr;
            3'd1:    fn = isa_pkg::fn_add;
            3'd2:    fn = isa_pkg::fn_sub;
            3'd3:    fn = isa_pkg::fn_and;
            default: fn = isa_pkg::fn_or;
        endcase
        return {op, 2'b00, r[9:7], 2'b00, r[12:10], 2'b00, r[15:13], 5'd0, fn};
    endfunction

    task automatic flag_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED at time %0t: %s", $time, msg);
    endtask

    task automatic drive_cycle(input logic [31:0] word, input logic cond = 1'b0,
                               input logic pause = 1'b0, input logic done = 1'b0,
                               input logic [31:0] pc_value = pc_run);
        @(negedge clk);
        instr               = word;
        condition_satisfied = cond;
        cpu_pause           = pause;
        uart_complete       = done;
        pc                  = pc_value;
    endtask

    // expected stage codes and issue, priority uart > pause > data > control
    always_comb begin : expect_rule
        logic data_h;
        logic uart_h;
        d                = decode_word(instr);
        d_slot.dest_idx  = d.dest_idx;
        d_slot.reg_write = d.reg_write;
        d_slot.mem_read  = d.load;
        uart_h           = pc > pc_limit;
        data_h           = (d.branch && (depends_on(m_ex, d) || depends_on(m_mem, d))) ||
                           (m_ex.mem_read && depends_on(m_ex, d));
        exp_ctrl         = fill_codes(hazard_pkg::ctrl_normal);
        exp_issue        = hazard_pkg::issue_none;
        case (exp_state)
            hazard_pkg::st_idle: exp_ctrl = fill_codes(hazard_pkg::ctrl_clear);
            hazard_pkg::st_execute: begin
                if (uart_h || cpu_pause) begin
                    exp_ctrl  = fill_codes(hazard_pkg::ctrl_stall);
                    exp_issue = uart_h ? hazard_pkg::issue_uart : hazard_pkg::issue_pause;
                end else if (data_h) begin                          // {wb, mem, ex, id, if}
                    exp_ctrl  = hazard_pkg::stage_ctrl_t'({hazard_pkg::ctrl_normal,
                        hazard_pkg::ctrl_normal, hazard_pkg::ctrl_clear,
                        hazard_pkg::ctrl_stall, hazard_pkg::ctrl_stall});
                    exp_issue = hazard_pkg::issue_data;
                end else if (d.branch && condition_satisfied) begin
                    exp_ctrl  = hazard_pkg::stage_ctrl_t'({hazard_pkg::ctrl_normal,
                        hazard_pkg::ctrl_normal, hazard_pkg::ctrl_normal,
                        hazard_pkg::ctrl_clear, hazard_pkg::ctrl_normal});
                    exp_issue = hazard_pkg::issue_control;
                end
            end
            hazard_pkg::st_pause: if (cpu_pause) begin
                exp_ctrl  = fill_codes(hazard_pkg::ctrl_stall);
                exp_issue = hazard_pkg::issue_pause;
            end
            default: if (uart_complete) begin
                exp_ctrl  = fill_codes(hazard_pkg::ctrl_clear);
            end else begin
                exp_ctrl  = fill_codes(hazard_pkg::ctrl_stall);
                exp_issue = hazard_pkg::issue_uart;
            end
        endcase
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (!rst_n) begin
            exp_state   <= hazard_pkg::st_idle;
            exp_issue_d <= hazard_pkg::issue_none;
            m_ex        <= '0;
            m_mem       <= '0;
        end else begin
            exp_issue_d <= exp_issue;
            m_ex        <= advance_slot(hazard_control[hazard_pkg::stage_ex], d_slot, m_ex);
            m_mem       <= advance_slot(hazard_control[hazard_pkg::stage_mem], m_ex, m_mem);
            case (exp_state)
                hazard_pkg::st_idle: exp_state <= hazard_pkg::st_execute;
                hazard_pkg::st_execute: begin
                    if (pc > pc_limit) exp_state <= hazard_pkg::st_interrupt;
                    else if (cpu_pause) exp_state <= hazard_pkg::st_pause;
                end
                hazard_pkg::st_pause: if (!cpu_pause) exp_state <= hazard_pkg::st_execute;
                default: if (uart_complete) exp_state <= hazard_pkg::st_execute;
            endcase
        end
    end

    reset_a: assert property (@(posedge clk) (!rst_n && cyc > 0) |->
        (cpu_state == hazard_pkg::st_idle && issue_type == hazard_pkg::issue_none &&
         hazard_control == fill_codes(hazard_pkg::ctrl_clear)))
    else flag_mismatch("outputs not idle during reset");

    wake_a: assert property (@(posedge clk) $rose(rst_n) |=> cpu_state == hazard_pkg::st_execute)
    else flag_mismatch("cpu_state not st_execute one cycle after reset release");

    ctrl_a: assert property (@(posedge clk) disable iff (!rst_n) hazard_control == exp_ctrl)
    else flag_mismatch("hazard_control differs from expected stage codes");

    state_a: assert property (@(posedge clk) disable iff (!rst_n) cpu_state == exp_state)
    else flag_mismatch("cpu_state differs from expected state");

    issue_a: assert property (@(posedge clk) disable iff (!rst_n) issue_type == exp_issue_d)
    else flag_mismatch("issue_type differs from delayed expected issue");

    pause_wins_a: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_state == hazard_pkg::st_execute && cpu_pause && pc <= pc_limit) |=>
        (issue_type == hazard_pkg::issue_pause && cpu_state == hazard_pkg::st_pause))
    else flag_mismatch("pause did not win or st_pause not entered");

    resume_a: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_state == hazard_pkg::st_interrupt && uart_complete) |=>
        cpu_state == hazard_pkg::st_execute)
    else flag_mismatch("no return to st_execute after uart_complete");

    initial begin
        #(timeout_limit);
        $display("timeout: the run did not finish within %0d time units", timeout_limit);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rng;
        logic [31:0] word;
        logic [31:0] nop;
        rng                 = 32'd22450;
        nop                 = 32'h0000_0000;                        // sll $0, writes nothing
        rst_n               = 1'b0;
        instr               = nop;
        pc                  = pc_run;
        condition_satisfied = 1'b0;
        cpu_pause           = 1'b0;
        uart_complete       = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        drive_cycle(nop);
        drive_cycle(nop);
        drive_cycle(encode_i(isa_pkg::op_lw, 5'd1, 5'd2));          // lw $2
        repeat (2) drive_cycle(encode_r(5'd2, 5'd4, 5'd3, isa_pkg::fn_add));  // held while stalled
        drive_cycle(nop);
        drive_cycle(encode_i(isa_pkg::op_addi, 5'd0, 5'd5));        // addi $5
        repeat (3) drive_cycle(encode_i(isa_pkg::op_beq, 5'd5, 5'd0));  // EX then MEM conflict
        drive_cycle(nop);
        drive_cycle(encode_i(isa_pkg::op_lw, 5'd1, 5'd7));          // lw $7
        drive_cycle(encode_i(isa_pkg::op_j, 5'd7, 5'd0));           // rs=7 but unused
        drive_cycle(nop);
        repeat (2) drive_cycle(nop);
        drive_cycle(encode_i(isa_pkg::op_beq, 5'd1, 5'd1), 1'b1);   // taken, no conflict
        drive_cycle(encode_i(isa_pkg::op_beq, 5'd1, 5'd1), 1'b0);   // not taken
        drive_cycle(nop);
        drive_cycle(encode_i(isa_pkg::op_lw, 5'd1, 5'd2));
        repeat (3) drive_cycle(encode_r(5'd2, 5'd4, 5'd3, isa_pkg::fn_add), 1'b0, 1'b1);
        drive_cycle(encode_r(5'd2, 5'd4, 5'd3, isa_pkg::fn_add));   // pause falls
        drive_cycle(nop);
        drive_cycle(nop, 1'b0, 1'b0, 1'b0, pc_out);                 // ran off the program
        repeat (3) drive_cycle(nop, 1'b0, 1'b0, 1'b0, pc_out);
        drive_cycle(nop, 1'b0, 1'b0, 1'b1, pc_run);                 // loader done
        drive_cycle(nop);
        for (int i = 0; i < random_cycles; i++) begin
            rng  = xorshift(rng);
            word = random_instr(rng);
            rng  = xorshift(rng);
            drive_cycle(word, rng[0], rng[15:10] == 6'd0, rng[17:16] == 2'b00,
                        (rng[27:22] == 6'd0) ? pc_out : pc_run);    // pause and uart rare
        end
        drive_cycle(nop);
        @(negedge clk);
        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* hazard_ctrl_top.sv */
module hazard_ctrl_top #(
    parameter logic [isa_pkg::isa_width-1:0] pc_max_value = 32'h0000_3ffc  // end of imem
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [isa_pkg::isa_width-1:0] instr,                // IF/ID instruction word
    input  logic [isa_pkg::isa_width-1:0] pc,
    input  logic                          condition_satisfied,
    input  logic                          cpu_pause,
    input  logic                          uart_complete,
    output hazard_pkg::stage_ctrl_t       hazard_control,       // to every stage register
    output hazard_pkg::cpu_state_e        cpu_state,            // to display
    output hazard_pkg::issue_e            issue_type            // to display
);

    hazard_pkg::decoded_instr_t id_info;
    hazard_pkg::pipe_info_t     ex_info;
    hazard_pkg::pipe_info_t     mem_info;

    instr_decoder u_decoder (
        .instr   (instr),
        .id_info (id_info)
    );

    pipe_tracker u_tracker (
        .clk            (clk),
        .rst_n          (rst_n),
        .id_info        (id_info),
        .hazard_control (hazard_control),                   // tracker follows the same codes
        .ex_info        (ex_info),
        .mem_info       (mem_info)
    );

    hazard_unit #(
        .pc_max_value (pc_max_value)
    ) u_hazard (
        .clk                 (clk),
        .rst_n               (rst_n),
        .id_info             (id_info),
        .ex_info             (ex_info),
        .mem_info            (mem_info),
        .pc                  (pc),
        .condition_satisfied (condition_satisfied),
        .cpu_pause           (cpu_pause),
        .uart_complete       (uart_complete),
        .hazard_control      (hazard_control),
        .cpu_state           (cpu_state),
        .issue_type          (issue_type)
    );

endmodule

/* hazard_unit.sv */
module hazard_unit #(
    parameter logic [isa_pkg::isa_width-1:0] pc_max_value = 32'h0000_3ffc  // last imem address
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  hazard_pkg::decoded_instr_t    id_info,
    input  hazard_pkg::pipe_info_t        ex_info,
    input  hazard_pkg::pipe_info_t        mem_info,
    input  logic [isa_pkg::isa_width-1:0] pc,
    input  logic                          condition_satisfied,  // branch taken
    input  logic                          cpu_pause,            // keypad level
    input  logic                          uart_complete,        // loader finished
    output hazard_pkg::stage_ctrl_t       hazard_control,
    output hazard_pkg::cpu_state_e        cpu_state,            // registered, for display
    output hazard_pkg::issue_e            issue_type            // registered, one cycle behind
);

    logic               ex_conflict;
    logic               mem_conflict;
    logic               data_hazard;
    logic               control_hazard;
    logic               pause_hazard;
    logic               uart_hazard;
    hazard_pkg::issue_e issue;                                  // winner of this cycle

    // slot writes a register that decode really reads
    function automatic logic conflict(input hazard_pkg::pipe_info_t     slot,
                                      input hazard_pkg::decoded_instr_t id);
        return slot.reg_write &&
               ((id.reg_1_valid && id.reg_1_idx == slot.dest_idx) ||
                (id.reg_2_valid && id.reg_2_idx == slot.dest_idx));
    endfunction

    function automatic hazard_pkg::stage_ctrl_t all_stages(input hazard_pkg::stage_ctrl_e code);
        hazard_pkg::stage_ctrl_t codes;
        for (int i = 0; i < hazard_pkg::stage_cnt; i++) begin
            codes[i] = code;
        end
        return codes;
    endfunction

    function automatic logic none_normal(input hazard_pkg::stage_ctrl_t codes);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < hazard_pkg::stage_cnt; i++) begin
            if (codes[i] == hazard_pkg::ctrl_normal) ok = 1'b0;
        end
        return ok;
    endfunction

    assign ex_conflict    = conflict(ex_info, id_info);
    assign mem_conflict   = conflict(mem_info, id_info);
    assign data_hazard    = (id_info.branch && (ex_conflict || mem_conflict)) ||  // compared in ID
                            (ex_info.mem_read && ex_conflict);                    // load-use
    assign control_hazard = id_info.branch && condition_satisfied;  // pc+4 fetch is wrong
    assign pause_hazard   = cpu_pause;
    assign uart_hazard    = pc > pc_max_value;                      // ran off the program

    always_comb begin
        hazard_control = hazard_pkg::stage_ctrl_t'(all_stages(hazard_pkg::ctrl_normal));
        issue          = hazard_pkg::issue_none;
        case (cpu_state)
            hazard_pkg::st_idle: hazard_control = all_stages(hazard_pkg::ctrl_clear);
            hazard_pkg::st_execute: begin
                if (uart_hazard || pause_hazard) begin             // freeze the whole pipe
                    hazard_control = all_stages(hazard_pkg::ctrl_stall);
                    issue = uart_hazard ? hazard_pkg::issue_uart : hazard_pkg::issue_pause;
                end else if (data_hazard) begin
                    hazard_control[hazard_pkg::stage_if] = hazard_pkg::ctrl_stall;
                    hazard_control[hazard_pkg::stage_id] = hazard_pkg::ctrl_stall;
                    hazard_control[hazard_pkg::stage_ex] = hazard_pkg::ctrl_clear;  // bubble
                    issue = hazard_pkg::issue_data;
                end else if (control_hazard) begin
                    hazard_control[hazard_pkg::stage_id] = hazard_pkg::ctrl_clear;  // drop pc+4
                    issue = hazard_pkg::issue_control;
                end
            end
            hazard_pkg::st_pause: begin
                if (cpu_pause) begin                                // resume as the level falls
                    hazard_control = all_stages(hazard_pkg::ctrl_stall);
                    issue          = hazard_pkg::issue_pause;
                end
            end
            default: begin                                          // st_interrupt
                if (uart_complete) begin
                    hazard_control = all_stages(hazard_pkg::ctrl_clear);  // restart clean
                end else begin
                    hazard_control = all_stages(hazard_pkg::ctrl_stall);
                    issue          = hazard_pkg::issue_uart;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cpu_state  <= hazard_pkg::st_idle;
            issue_type <= hazard_pkg::issue_none;
        end else begin
            issue_type <= issue;
            case (cpu_state)
                hazard_pkg::st_idle: cpu_state <= hazard_pkg::st_execute;
                hazard_pkg::st_execute: begin
                    if (uart_hazard)       cpu_state <= hazard_pkg::st_interrupt;
                    else if (pause_hazard) cpu_state <= hazard_pkg::st_pause;
                end
                hazard_pkg::st_pause: if (!cpu_pause) cpu_state <= hazard_pkg::st_execute;
                default: if (uart_complete) cpu_state <= hazard_pkg::st_execute;
            endcase
        end
    end

    // an EX bubble always pairs with a held or flushed decode stage
    ex_clear_holds_id_a: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_state == hazard_pkg::st_execute &&
         hazard_control[hazard_pkg::stage_ex] == hazard_pkg::ctrl_clear)
        |-> hazard_control[hazard_pkg::stage_id] != hazard_pkg::ctrl_normal)
    else $error("EX cleared while ID advances");

    // nothing advances while the loader owns the CPU
    interrupt_frozen_a: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_state == hazard_pkg::st_interrupt |-> none_normal(hazard_control))
    else $error("stage advanced during interrupt");

endmodule

/* pipe_tracker.sv */
module pipe_tracker (
    input  logic                       clk,
    input  logic                       rst_n,
    input  hazard_pkg::decoded_instr_t id_info,         // instruction leaving decode
    input  hazard_pkg::stage_ctrl_t    hazard_control,  // per stage codes this cycle
    output hazard_pkg::pipe_info_t     ex_info,         // slot in ID/EX
    output hazard_pkg::pipe_info_t     mem_info         // slot in EX/MEM
);

    localparam hazard_pkg::pipe_info_t bubble = '0;     // writes nothing, reads nothing

    hazard_pkg::pipe_info_t id_slot;

    // the part of decode that travels down the pipe
    assign id_slot.dest_idx  = id_info.dest_idx;
    assign id_slot.reg_write = id_info.reg_write;
    assign id_slot.mem_read  = id_info.load;

    // one stage register step under its control code
    function automatic hazard_pkg::pipe_info_t step_slot(
        input hazard_pkg::stage_ctrl_e code,
        input hazard_pkg::pipe_info_t  upstream,
        input hazard_pkg::pipe_info_t  current
    );
        hazard_pkg::pipe_info_t nxt;
        case (code)
            hazard_pkg::ctrl_normal: nxt = upstream;    // advance
            hazard_pkg::ctrl_clear:  nxt = bubble;      // flush
            default:                 nxt = current;     // stall holds
        endcase
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_info  <= bubble;
            mem_info <= bubble;
        end else begin
            ex_info  <= step_slot(hazard_control[hazard_pkg::stage_ex], id_slot, ex_info);
            mem_info <= step_slot(hazard_control[hazard_pkg::stage_mem], ex_info, mem_info);
        end
    end

    // a cleared slot must not look like a pending register write
    ex_bubble_a: assert property (@(posedge clk) disable iff (!rst_n)
        hazard_control[hazard_pkg::stage_ex] == hazard_pkg::ctrl_clear |=> !ex_info.reg_write)
    else $error("EX slot still writes a register after a clear");

    mem_bubble_a: assert property (@(posedge clk) disable iff (!rst_n)
        hazard_control[hazard_pkg::stage_mem] == hazard_pkg::ctrl_clear |=> !mem_info.reg_write)
    else $error("MEM slot still writes a register after a clear");

endmodule

/* instr_decoder.sv */
module instr_decoder (
    input  logic [isa_pkg::isa_width-1:0] instr,        // word held in IF/ID
    output hazard_pkg::decoded_instr_t    id_info       // class flags and register indices
);

    isa_pkg::opcode_e                  opcode;
    isa_pkg::funct_e                   funct;
    logic [isa_pkg::reg_idx_width-1:0] rs;
    logic [isa_pkg::reg_idx_width-1:0] rt;
    logic [isa_pkg::reg_idx_width-1:0] rd;

    assign opcode = isa_pkg::opcode_e'(instr[isa_pkg::opcode_lsb +: isa_pkg::opcode_width]);
    assign funct  = isa_pkg::funct_e'(instr[isa_pkg::funct_lsb +: isa_pkg::funct_width]);
    assign rs     = instr[isa_pkg::rs_lsb +: isa_pkg::reg_idx_width];
    assign rt     = instr[isa_pkg::rt_lsb +: isa_pkg::reg_idx_width];
    assign rd     = instr[isa_pkg::rd_lsb +: isa_pkg::reg_idx_width];

    always_comb begin
        id_info           = '0;
        id_info.reg_1_idx = rs;                         // always rs, validity decides use
        id_info.reg_2_idx = rt;

        case (opcode)
            isa_pkg::op_rtype: begin
                if (funct == isa_pkg::fn_jr) begin
                    id_info.jr = 1'b1;                  // jumps to rs, writes nothing
                end else begin
                    id_info.r_type = 1'b1;
                end
            end
            isa_pkg::op_j:      id_info.j      = 1'b1;
            isa_pkg::op_jal:    id_info.jal    = 1'b1;
            isa_pkg::op_beq,
            isa_pkg::op_bne:    id_info.branch = 1'b1;
            isa_pkg::op_addi,
            isa_pkg::op_andi,
            isa_pkg::op_ori,
            isa_pkg::op_lui:    id_info.i_type = 1'b1;
            isa_pkg::op_lw:     id_info.load   = 1'b1;
            isa_pkg::op_sw:     id_info.store  = 1'b1;
            default: ;                                  // unknown opcode stays a no-op
        endcase

        id_info.reg_1_valid = !(id_info.j || id_info.jal);     // jump target is immediate
        id_info.reg_2_valid = id_info.r_type || id_info.branch || id_info.store;

        if (id_info.r_type) begin
            id_info.dest_idx = rd;
        end else if (id_info.i_type || id_info.load) begin
            id_info.dest_idx = rt;
        end else if (id_info.jal) begin
            id_info.dest_idx = isa_pkg::link_reg_idx;  // return address
        end

        // $zero never counts as a write target
        id_info.reg_write = (id_info.r_type || id_info.i_type || id_info.load || id_info.jal) &&
                            (id_info.dest_idx != '0);
    end

    // instruction classes that steer control or memory must be exclusive
    always_comb begin
        assert ($onehot0({id_info.j, id_info.jal, id_info.jr,
                          id_info.branch, id_info.store, id_info.load}))
        else $error("decoder raised more than one exclusive class flag");
    end

endmodule

/* hazard_pkg.sv */
package hazard_pkg;

    localparam int stage_cnt = 5;                   // one control code per stage register

    localparam int stage_if  = 0;
    localparam int stage_id  = 1;
    localparam int stage_ex  = 2;
    localparam int stage_mem = 3;
    localparam int stage_wb  = 4;

    typedef enum logic [1:0] {
        ctrl_normal = 2'b00,                        // load from previous stage
        ctrl_stall  = 2'b01,                        // keep current contents
        ctrl_clear  = 2'b10                         // load a bubble
    } stage_ctrl_e;

    // hazard_control bundle, indexed by the stage indices above
    typedef stage_ctrl_e [stage_cnt-1:0] stage_ctrl_t;

    typedef enum logic [1:0] {
        st_idle      = 2'b00,                       // held in reset
        st_execute   = 2'b01,
        st_pause     = 2'b10,                       // keypad pause
        st_interrupt = 2'b11                        // waiting for the uart loader
    } cpu_state_e;

    typedef enum logic [2:0] {
        issue_none    = 3'd0,
        issue_data    = 3'd1,
        issue_control = 3'd2,
        issue_pause   = 3'd3,
        issue_uart    = 3'd4
    } issue_e;

    // instruction in IF/ID after classification
    typedef struct packed {
        logic i_type;                               // addi, andi, ori, lui
        logic r_type;                               // R-type except jr
        logic j;
        logic jr;
        logic jal;
        logic branch;                               // beq, bne
        logic store;
        logic load;
        logic reg_write;                            // writes a nonzero register
        logic reg_1_valid;                          // rs is really read
        logic reg_2_valid;                          // rt is really read
        logic [isa_pkg::reg_idx_width-1:0] reg_1_idx;
        logic [isa_pkg::reg_idx_width-1:0] reg_2_idx;
        logic [isa_pkg::reg_idx_width-1:0] dest_idx;
    } decoded_instr_t;

    // what the hazard unit needs to know about an instruction in EX or MEM
    typedef struct packed {
        logic [isa_pkg::reg_idx_width-1:0] dest_idx;
        logic reg_write;
        logic mem_read;                             // load, data arrives late
    } pipe_info_t;

endpackage

/* isa_pkg.sv */
package isa_pkg;

    localparam int isa_width     = 32;              // instruction word and pc width
    localparam int reg_idx_width = 5;               // 32 general purpose registers
    localparam int opcode_width  = 6;
    localparam int funct_width   = 6;

    // field positions inside the instruction word
    localparam int opcode_lsb = 26;                 // bits 31:26
    localparam int rs_lsb     = 21;                 // bits 25:21, first source
    localparam int rt_lsb     = 16;                 // bits 20:16, second source or I-type dest
    localparam int rd_lsb     = 11;                 // bits 15:11, R-type dest
    localparam int funct_lsb  = 0;                  // bits 5:0, R-type function

    localparam logic [reg_idx_width-1:0] link_reg_idx = 5'd31;  // $ra, written by jal

    typedef enum logic [opcode_width-1:0] {
        op_rtype = 6'h00,                           // function field selects the operation
        op_j     = 6'h02,
        op_jal   = 6'h03,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addi  = 6'h08,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_lui   = 6'h0f,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_e;

    typedef enum logic [funct_width-1:0] {
        fn_jr  = 6'h08,                             // only R-type without a destination
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25
    } funct_e;

endpackage
